// File: hdl/lc_pkg.sv
package lc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Datapath widths

   localparam int LC_W = 26;
   localparam int OPC_W = 14;
   // Shared by the PDL pointer, PDL index and dispatch constant
   localparam int PDL_W = 10;

   ////////////////////////////////////////////////////////////////////////////
   // Microcycle phases and STEP opcodes

   typedef enum logic [2:0] {
      IDLE,
      ALU,
      WRITE,
      MMU,
      FETCH
   } ucycle_e;

   // Written in bits 2:0 of REG_STEP
   typedef enum logic [2:0] {
      NOP,
      INC,
      LOAD,
      PUSH,
      POP
   } step_op_e;

   // M-function source select, CTRL bits 2:0
   typedef enum logic [2:0] {
      MF_LC,
      MF_OPC,
      MF_DC,
      MF_PP,
      MF_PI,
      MF_ZERO
   } mf_sel_e;

   ////////////////////////////////////////////////////////////////////////////
   // APB register map, byte addresses

   localparam logic [7:0] REG_LC = 8'h00;
   localparam logic [7:0] REG_CTRL = 8'h04;
   localparam logic [7:0] REG_STEP = 8'h08;
   localparam logic [7:0] REG_MF = 8'h0C;
   localparam logic [7:0] REG_DC = 8'h10;
   localparam logic [7:0] REG_PDLIDX = 8'h14;

endpackage

// File: hdl/mf_src_if.sv
// M-function sources that live outside the location counter block.
// Several modules each drive their own part of the producer side.
interface mf_src_if #(
   parameter int OPC_W = 14,
   parameter int PDL_W = 10
);

   // Old PC from the last fetch
   logic [OPC_W-1:0] opc;
   // Dispatch constant
   logic [PDL_W-1:0] dc;
   // Push-down list pointer and index
   logic [PDL_W-1:0] pdlptr;
   logic [PDL_W-1:0] pdlidx;

   modport producer (
      output opc,
      output dc,
      output pdlptr,
      output pdlidx
   );

   modport consumer (
      input opc,
      input dc,
      input pdlptr,
      input pdlidx
   );

endinterface

// File: hdl/lc_apb_ctrl.sv
module lc_apb_ctrl #(
   parameter int ADDR_W = 8
) (
   input  logic                    clk,
   input  logic                    reset,
   // APB slave
   input  logic [ADDR_W-1:0]       paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [31:0]             pwdata,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr,
   // Read-back sources
   input  logic [lc_pkg::LC_W-1:0] lc,
   input  logic [31:0]             mf,
   // Microcycle phases
   output logic                    state_alu,
   output logic                    state_write,
   output logic                    state_mmu,
   output logic                    state_fetch,
   // Strobes
   output logic                    destlc,
   output logic                    lcinc,
   output logic                    pdl_push,
   output logic                    pdl_pop,
   output logic                    pdlidx_load,
   output logic [lc_pkg::LC_W-1:0] load_data,
   output lc_pkg::mf_sel_e         mf_sel,
   // CTRL flags
   output logic                    lc_byte_mode,
   output logic                    needfetch,
   output logic                    int_enable,
   output logic                    sequence_break,
   output logic                    prog_unibus_reset,
   mf_src_if.producer              src
);

   lc_pkg::ucycle_e           state;
   lc_pkg::step_op_e          step_op;
   lc_pkg::step_op_e          wr_op;
   logic [4:0]                flags;
   logic [lc_pkg::PDL_W-1:0]  dc;
   logic                      access;
   logic                      first;
   logic                      mapped;
   logic                      wr;
   logic                      long_op;
   logic                      step_start;
   logic                      busy;

   ////////////////////////////////////////////////////////////////////////////
   // APB decode

   assign access = psel && penable;
   assign first = access && (state == lc_pkg::IDLE);
   assign wr_op = lc_pkg::step_op_e'(pwdata[2:0]);
   assign long_op = (wr_op == lc_pkg::INC) || (wr_op == lc_pkg::LOAD) ||
                    (wr_op == lc_pkg::PUSH) || (wr_op == lc_pkg::POP);

   always_comb begin
      case (paddr)
         ADDR_W'(lc_pkg::REG_LC),
         ADDR_W'(lc_pkg::REG_CTRL),
         ADDR_W'(lc_pkg::REG_STEP),
         ADDR_W'(lc_pkg::REG_MF),
         ADDR_W'(lc_pkg::REG_DC),
         ADDR_W'(lc_pkg::REG_PDLIDX): mapped = 1'b1;
         default:                     mapped = 1'b0;
      endcase
   end

   assign pslverr = access && !mapped;
   assign wr = first && pwrite && mapped;
   assign step_start = wr && (paddr == ADDR_W'(lc_pkg::REG_STEP)) && long_op;

   // A STEP sequence stretches the access until FETCH
   assign pready = (state == lc_pkg::FETCH) || (first && !step_start);

   // Index loads as the access completes
   assign pdlidx_load = wr && (paddr == ADDR_W'(lc_pkg::REG_PDLIDX));

   // CTRL layout: mf_sel in 2:0, then byte mode, needfetch, int enable,
   // sequence break and unibus reset in bits 4 through 8
   always_comb begin
      case (paddr)
         ADDR_W'(lc_pkg::REG_LC):   prdata = 32'(lc);
         ADDR_W'(lc_pkg::REG_CTRL): prdata = {23'b0, flags, 1'b0, mf_sel};
         ADDR_W'(lc_pkg::REG_MF):   prdata = mf;
         ADDR_W'(lc_pkg::REG_DC):   prdata = 32'(dc);
         default:                   prdata = 32'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Host registers

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
         mf_sel <= lc_pkg::MF_LC;
         dc <= '0;
         load_data <= '0;
      end else if (wr) begin
         if (paddr == ADDR_W'(lc_pkg::REG_CTRL)) begin
            mf_sel <= lc_pkg::mf_sel_e'(pwdata[2:0]);
            flags <= pwdata[8:4];
         end
         if (paddr == ADDR_W'(lc_pkg::REG_DC))
            dc <= pwdata[lc_pkg::PDL_W-1:0];
         // LC write only stages the value for a later LOAD
         if (paddr == ADDR_W'(lc_pkg::REG_LC))
            load_data <= pwdata[lc_pkg::LC_W-1:0];
      end
   end

   assign lc_byte_mode = flags[0];
   assign needfetch = flags[1];
   assign int_enable = flags[2];
   assign sequence_break = flags[3];
   assign prog_unibus_reset = flags[4];
   assign src.dc = dc;

   ////////////////////////////////////////////////////////////////////////////
   // Microcycle sequencer

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= lc_pkg::IDLE;
         step_op <= lc_pkg::NOP;
      end else begin
         case (state)
            lc_pkg::IDLE: begin
               if (step_start) begin
                  state <= lc_pkg::ALU;
                  step_op <= wr_op;
               end
            end
            lc_pkg::ALU:   state <= lc_pkg::WRITE;
            lc_pkg::WRITE: state <= lc_pkg::MMU;
            lc_pkg::MMU:   state <= lc_pkg::FETCH;
            default:       state <= lc_pkg::IDLE;
         endcase
      end
   end

   assign state_alu = (state == lc_pkg::ALU);
   assign state_write = (state == lc_pkg::WRITE);
   assign state_mmu = (state == lc_pkg::MMU);
   assign state_fetch = (state == lc_pkg::FETCH);
   assign busy = (state != lc_pkg::IDLE);

   // Opcode strobes held for the whole sequence
   assign lcinc = busy && (step_op == lc_pkg::INC);
   assign destlc = busy && (step_op == lc_pkg::LOAD);
   assign pdl_push = busy && (step_op == lc_pkg::PUSH);
   assign pdl_pop = busy && (step_op == lc_pkg::POP);

   a_one_phase: assert property (@(posedge clk) disable iff (reset)
      busy |-> $onehot({state_alu, state_write, state_mmu, state_fetch}));

endmodule

// File: hdl/lc_unit.sv
module lc_unit #(
   parameter int LC_W = 26
) (
   input  logic            clk,
   input  logic            reset,
   // Microcycle phases
   input  logic            state_alu,
   input  logic            state_write,
   input  logic            state_mmu,
   input  logic            state_fetch,
   // Counter control
   input  logic            destlc,
   input  logic            lcinc,
   input  logic [LC_W-1:0] load_data,
   input  lc_pkg::mf_sel_e mf_sel,
   // Flags packed into the LC read-back word
   input  logic            lc_byte_mode,
   input  logic            needfetch,
   input  logic            int_enable,
   input  logic            sequence_break,
   input  logic            prog_unibus_reset,
   mf_src_if.consumer      src,
   output logic [LC_W-1:0] lc,
   output logic [31:0]     mf
);

   logic [3:0] lca;
   logic       lcry3;
   logic       lc0b;
   logic       busy;

   ////////////////////////////////////////////////////////////////////////////
   // Location counter

   // Byte mode adds 1, word mode adds 2; bit 0 is left alone in word mode
   assign {lcry3, lca} = lc[3:0] + {3'b0, lcinc & ~lc_byte_mode} + {3'b0, lcinc};

   always_ff @(posedge clk) begin
      if (reset) begin
         lc <= '0;
      end else if (state_fetch) begin
         if (destlc)
            lc <= load_data;
         else
            lc <= {lc[LC_W-1:4] + (LC_W-4)'(lcry3), lca};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // M-function source select

   // Low byte select only means something in byte mode
   assign lc0b = lc[0] & lc_byte_mode;

   always_comb begin
      case (mf_sel)
         lc_pkg::MF_LC:   mf = {needfetch, 1'b0, lc_byte_mode, prog_unibus_reset,
                                int_enable, sequence_break, lc[LC_W-1:1], lc0b};
         lc_pkg::MF_OPC:  mf = 32'(src.opc);
         lc_pkg::MF_DC:   mf = 32'(src.dc);
         lc_pkg::MF_PP:   mf = 32'(src.pdlptr);
         lc_pkg::MF_PI:   mf = 32'(src.pdlidx);
         lc_pkg::MF_ZERO: mf = 32'b0;
         default:         mf = 32'b0;
      endcase
   end

   assign busy = state_alu || state_write || state_mmu || state_fetch;

   // Counter strobes come from one decoded opcode and only inside a sequence
   a_lc_strobes: assert property (@(posedge clk) disable iff (reset)
      (destlc || lcinc) |-> (busy && !(destlc && lcinc)));

   // Word stepping must keep the byte select bit
   a_word_bit0: assert property (@(posedge clk) disable iff (reset)
      (state_fetch && lcinc && !lc_byte_mode) |=> (lc[0] == $past(lc[0])));

endmodule

// File: hdl/opc_history.sv
module opc_history #(
   parameter int OPC_W = 14
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    state_fetch,
   input  logic [lc_pkg::LC_W-1:0] lc,
   mf_src_if.producer              src
);

   logic [OPC_W-1:0] opc;

   ////////////////////////////////////////////////////////////////////////////
   // Old PC capture

   // Sampled on the same edge that commits lc, so this holds
   // the address the finished instruction came from
   always_ff @(posedge clk) begin
      if (reset)
         opc <= '0;
      else if (state_fetch)
         opc <= lc[OPC_W-1:0];
   end

   assign src.opc = opc;

endmodule

// File: hdl/pdl_pointer.sv
module pdl_pointer #(
   parameter int PDL_W = 10
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        state_fetch,
   input  logic        pdl_push,
   input  logic        pdl_pop,
   input  logic        pdlidx_load,
   input  logic [31:0] pwdata,
   mf_src_if.producer  src
);

   logic [PDL_W-1:0] pdlptr;
   logic [PDL_W-1:0] pdlidx;

   ////////////////////////////////////////////////////////////////////////////
   // Pointer, moves once per fetch

   // Wraps modulo 2**PDL_W in both directions
   always_ff @(posedge clk) begin
      if (reset) begin
         pdlptr <= '0;
      end else if (state_fetch) begin
         if (pdl_push)
            pdlptr <= pdlptr + 1'b1;
         else if (pdl_pop)
            pdlptr <= pdlptr - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Index, loaded straight from the host

   always_ff @(posedge clk) begin
      if (reset)
         pdlidx <= '0;
      else if (pdlidx_load)
         pdlidx <= pwdata[PDL_W-1:0];
   end

   assign src.pdlptr = pdlptr;
   assign src.pdlidx = pdlidx;

   a_push_pop: assert property (@(posedge clk) disable iff (reset)
      !(pdl_push && pdl_pop));

endmodule

// File: hdl/lc_top.sv
module lc_top (
   input  logic        clk,
   input  logic        reset,
   input  logic [7:0]  paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   localparam int ADDR_W = 8;

   logic                    state_alu;
   logic                    state_write;
   logic                    state_mmu;
   logic                    state_fetch;
   logic                    destlc;
   logic                    lcinc;
   logic                    pdl_push;
   logic                    pdl_pop;
   logic                    pdlidx_load;
   logic [lc_pkg::LC_W-1:0] load_data;
   lc_pkg::mf_sel_e         mf_sel;
   logic                    lc_byte_mode;
   logic                    needfetch;
   logic                    int_enable;
   logic                    sequence_break;
   logic                    prog_unibus_reset;
   logic [lc_pkg::LC_W-1:0] lc;
   logic [31:0]             mf;

   mf_src_if #(
      .OPC_W(lc_pkg::OPC_W),
      .PDL_W(lc_pkg::PDL_W)
   ) mf_src ();

   ////////////////////////////////////////////////////////////////////////////
   // Host side and sequencer

   lc_apb_ctrl #(
      .ADDR_W(ADDR_W)
   ) lc_apb_ctrl_inst (
      .clk(clk),
      .reset(reset),
      .paddr(paddr),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .lc(lc),
      .mf(mf),
      .state_alu(state_alu),
      .state_write(state_write),
      .state_mmu(state_mmu),
      .state_fetch(state_fetch),
      .destlc(destlc),
      .lcinc(lcinc),
      .pdl_push(pdl_push),
      .pdl_pop(pdl_pop),
      .pdlidx_load(pdlidx_load),
      .load_data(load_data),
      .mf_sel(mf_sel),
      .lc_byte_mode(lc_byte_mode),
      .needfetch(needfetch),
      .int_enable(int_enable),
      .sequence_break(sequence_break),
      .prog_unibus_reset(prog_unibus_reset),
      .src(mf_src.producer)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Counter, history and PDL

   lc_unit #(
      .LC_W(lc_pkg::LC_W)
   ) lc_unit_inst (
      .clk(clk),
      .reset(reset),
      .state_alu(state_alu),
      .state_write(state_write),
      .state_mmu(state_mmu),
      .state_fetch(state_fetch),
      .destlc(destlc),
      .lcinc(lcinc),
      .load_data(load_data),
      .mf_sel(mf_sel),
      .lc_byte_mode(lc_byte_mode),
      .needfetch(needfetch),
      .int_enable(int_enable),
      .sequence_break(sequence_break),
      .prog_unibus_reset(prog_unibus_reset),
      .src(mf_src.consumer),
      .lc(lc),
      .mf(mf)
   );

   opc_history #(
      .OPC_W(lc_pkg::OPC_W)
   ) opc_history_inst (
      .clk(clk),
      .reset(reset),
      .state_fetch(state_fetch),
      .lc(lc),
      .src(mf_src.producer)
   );

   pdl_pointer #(
      .PDL_W(lc_pkg::PDL_W)
   ) pdl_pointer_inst (
      .clk(clk),
      .reset(reset),
      .state_fetch(state_fetch),
      .pdl_push(pdl_push),
      .pdl_pop(pdl_pop),
      .pdlidx_load(pdlidx_load),
      .pwdata(pwdata),
      .src(mf_src.producer)
   );

endmodule

// File: sim/lc_tb.sv
module lc_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // Worst access is a STEP: setup, five access cycles and one idle cycle
   localparam int ACCESS_BUDGET = 450;
   localparam int TIMEOUT_CYCLES = ACCESS_BUDGET * 8 + 400;

   logic        clk;
   logic        reset;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          tests;
   int          errors_at_start;
   int          cycle_count;
   string       test_name;

   // Shadow model
   logic [25:0] m_lc;
   logic [25:0] m_load;
   logic [13:0] m_opc;
   logic [9:0]  m_pdlptr;
   logic [9:0]  m_pdlidx;
   logic [9:0]  m_dc;
   logic [4:0]  m_flags;
   logic [2:0]  m_sel;

   lc_top lc_top_inst (
      .clk(clk),
      .reset(reset),
      .paddr(paddr),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Protocol assertions

   function automatic logic is_mapped(input logic [7:0] addr);
      return addr == lc_pkg::REG_LC || addr == lc_pkg::REG_CTRL ||
             addr == lc_pkg::REG_STEP || addr == lc_pkg::REG_MF ||
             addr == lc_pkg::REG_DC || addr == lc_pkg::REG_PDLIDX;
   endfunction

   // INC through POP run the full microcycle
   a_step_ready: assert property (@(posedge clk) disable iff (reset)
      (psel && $rose(penable) && pwrite && paddr == lc_pkg::REG_STEP &&
       pwdata[2:0] >= lc_pkg::INC && pwdata[2:0] <= lc_pkg::POP)
      |-> !pready ##1 !pready ##1 !pready ##1 !pready ##1 pready)
      else begin
         errors++;
         $display("ERROR: STEP access did not stall four cycles then complete at %0t", $time);
      end

   a_slverr: assert property (@(posedge clk) disable iff (reset)
      (psel && penable) |-> (pslverr == !is_mapped(paddr)))
      else begin
         errors++;
         $display("ERROR: pslverr wrong for address %h at %0t", paddr, $time);
      end

   a_idle_ready: assert property (@(posedge clk) disable iff (reset)
      !(psel && penable) |-> !pready)
      else begin
         errors++;
         $display("ERROR: pready high outside an access at %0t", $time);
      end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic apb_access(input logic [7:0] addr, input logic write,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err, output int cycles);
      @(posedge clk);
      #2;
      paddr = addr;
      pwrite = write;
      pwdata = wdata;
      psel = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #2;
      penable = 1'b1;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!pready);
      rdata = prdata;
      err = pslverr;
      #2;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      int          cyc;
      apb_access(addr, 1'b1, data, rd, err, cyc);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      int   cyc;
      apb_access(addr, 1'b0, 32'b0, data, err, cyc);
   endtask

   task automatic set_ctrl(input logic [2:0] sel, input logic [4:0] flags);
      apb_write(lc_pkg::REG_CTRL, {23'b0, flags, 1'b0, sel});
      m_sel = sel;
      m_flags = flags;
   endtask

   task automatic read_mf(input logic [2:0] sel, output logic [31:0] data);
      set_ctrl(sel, m_flags);
      apb_read(lc_pkg::REG_MF, data);
   endtask

   // Old PC takes the counter before the fetch commit
   task automatic do_step(input logic [2:0] op);
      logic [31:0] rd;
      logic        err;
      int          cyc;
      logic        long_op;
      long_op = (op >= lc_pkg::INC && op <= lc_pkg::POP);
      apb_access(lc_pkg::REG_STEP, 1'b1, {29'b0, op}, rd, err, cyc);
      check_value(long_op ? 32'd5 : 32'd1, 32'(cyc));
      if (long_op) begin
         m_opc = m_lc[13:0];
         case (op)
            lc_pkg::INC:  m_lc = m_lc + (m_flags[0] ? 26'd1 : 26'd2);
            lc_pkg::LOAD: m_lc = m_load;
            lc_pkg::PUSH: m_pdlptr = m_pdlptr + 10'd1;
            lc_pkg::POP:  m_pdlptr = m_pdlptr - 10'd1;
            default:      ;
         endcase
      end
   endtask

   task automatic stage_load(input logic [25:0] value);
      apb_write(lc_pkg::REG_LC, {6'b0, value});
      m_load = value;
   endtask

   task automatic load_lc(input logic [25:0] value);
      stage_load(value);
      do_step(lc_pkg::LOAD);
   endtask

   // needfetch, 0, byte mode, unibus reset, int enable, sequence break, lc[25:1], lc0b
   function automatic logic [31:0] expected_lc_word();
      return {m_flags[1], 1'b0, m_flags[0], m_flags[4], m_flags[2], m_flags[3],
              m_lc[25:1], m_lc[0] & m_flags[0]};
   endfunction

   task automatic start_test(input string name);
      test_name = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests++;
      $display("test %s done, %0d errors", test_name, errors - errors_at_start);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      logic [31:0] rd;
      logic [31:0] v;
      logic [31:0] n;
      logic        err;
      int          cyc;
      logic [7:0]  bad_addr [4];

      bad_addr = '{8'h02, 8'h18, 8'h40, 8'hFC};
      reset = 1'b1;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      lfsr = 32'h4f646453;
      errors = 0;
      checks = 0;
      tests = 0;
      m_lc = '0;
      m_load = '0;
      m_opc = '0;
      m_pdlptr = '0;
      m_pdlidx = '0;
      m_dc = '0;
      m_flags = '0;
      m_sel = '0;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      start_test("reset_values");
      apb_read(lc_pkg::REG_LC, rd);
      check_value(32'b0, rd);
      apb_read(lc_pkg::REG_CTRL, rd);
      check_value(32'b0, rd);
      for (int s = 0; s < 6; s++) begin
         read_mf(3'(s), rd);
         check_value(32'b0, rd);
      end
      finish_test();

      start_test("increment");
      for (int i = 0; i < 12; i++) begin
         take_bits(26, v);
         // Low nibble near the top so the carry crosses bit 3
         if (i % 3 == 0)
            v[3:0] = 4'hE | {3'b0, v[0]};
         if (i == 11)
            v[25:0] = 26'h3FFFFFE;
         set_ctrl(lc_pkg::MF_LC, {4'b0, i[0]});
         load_lc(v[25:0]);
         take_bits(2, n);
         for (int k = 0; k <= int'(n); k++)
            do_step(lc_pkg::INC);
         apb_read(lc_pkg::REG_LC, rd);
         check_value({6'b0, m_lc}, rd);
      end
      finish_test();

      start_test("old_pc");
      set_ctrl(lc_pkg::MF_OPC, m_flags);
      for (int i = 0; i < 8; i++) begin
         take_bits(26, v);
         stage_load(v[25:0]);
         take_bits(2, n);
         if (n[1:0] == 2'd0)
            do_step(lc_pkg::NOP);
         else if (n[1:0] == 2'd1)
            do_step(lc_pkg::LOAD);
         else
            do_step(lc_pkg::INC);
         apb_read(lc_pkg::REG_MF, rd);
         check_value({18'b0, m_opc}, rd);
      end
      finish_test();

      start_test("pdl");
      set_ctrl(lc_pkg::MF_PP, m_flags);
      // Pop below zero, then push back over the top
      for (int i = 0; i < 24; i++) begin
         take_bits(1, n);
         if (i == 1 || (i > 3 && n[0]))
            do_step(lc_pkg::PUSH);
         else
            do_step(lc_pkg::POP);
         apb_read(lc_pkg::REG_MF, rd);
         check_value({22'b0, m_pdlptr}, rd);
      end
      for (int i = 0; i < 3; i++) begin
         take_bits(32, v);
         apb_write(lc_pkg::REG_PDLIDX, v);
         m_pdlidx = v[9:0];
         read_mf(lc_pkg::MF_PI, rd);
         check_value({22'b0, m_pdlidx}, rd);
      end
      finish_test();

      start_test("mf_word");
      for (int i = 0; i < 8; i++) begin
         take_bits(5, n);
         n[0] = i[0];
         take_bits(26, v);
         v[0] = i[1];
         set_ctrl(lc_pkg::MF_LC, n[4:0]);
         load_lc(v[25:0]);
         apb_read(lc_pkg::REG_MF, rd);
         check_value(expected_lc_word(), rd);
         apb_read(lc_pkg::REG_CTRL, rd);
         check_value({23'b0, m_flags, 1'b0, m_sel}, rd);
      end
      for (int i = 0; i < 3; i++) begin
         take_bits(32, v);
         apb_write(lc_pkg::REG_DC, v);
         m_dc = v[9:0];
         read_mf(lc_pkg::MF_DC, rd);
         check_value({22'b0, m_dc}, rd);
      end
      finish_test();

      start_test("apb_protocol");
      do_step(lc_pkg::INC);
      do_step(lc_pkg::NOP);
      do_step(lc_pkg::PUSH);
      for (int i = 0; i < 4; i++) begin
         take_bits(32, v);
         apb_access(bad_addr[i], 1'b1, v, rd, err, cyc);
         check_value(32'd1, {31'b0, err});
         check_value(32'd1, 32'(cyc));
         apb_access(bad_addr[i], 1'b0, 32'b0, rd, err, cyc);
         check_value(32'd1, {31'b0, err});
      end
      apb_read(lc_pkg::REG_LC, rd);
      check_value({6'b0, m_lc}, rd);
      apb_read(lc_pkg::REG_CTRL, rd);
      check_value({23'b0, m_flags, 1'b0, m_sel}, rd);
      apb_read(lc_pkg::REG_DC, rd);
      check_value({22'b0, m_dc}, rd);
      read_mf(lc_pkg::MF_PI, rd);
      check_value({22'b0, m_pdlidx}, rd);
      read_mf(lc_pkg::MF_PP, rd);
      check_value({22'b0, m_pdlptr}, rd);
      finish_test();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: build.f
hdl/lc_pkg.sv
hdl/mf_src_if.sv
hdl/lc_apb_ctrl.sv
hdl/lc_unit.sv
hdl/opc_history.sv
hdl/pdl_pointer.sv
hdl/lc_top.sv
sim/lc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run the testbench, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lc_tb -f build.f \
   -o lc_sim > build.log 2>&1 \
   || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/lc_sim > sim.log 2>&1 \
   && grep -qx "PASS: all tests" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
